//--- include/tlb_settings.svh
`ifndef TLB_SETTINGS_SVH
`define TLB_SETTINGS_SVH

// number of TLB entries.
`define TLB_NUM 16

// entry index width, ceil(log2(TLB_NUM)).
`define TLB_IDX_W $clog2(`TLB_NUM)

// virtual address width.
`define TLB_VA_W 32

`endif

//--- hw/tlb_entry_pkg.sv
`include "tlb_settings.svh"

package tlb_entry_pkg;

    // ps code of a 4MB huge page; anything else is treated as 4KB.
    localparam logic [5:0] PS_4M = 6'd21;

    typedef struct packed {
        logic [19:0] pfn;
        logic [1:0]  mat;
        logic [1:0]  plv;
        logic        d;
        logic        v;
    } tlb_page_t;

    typedef struct packed {
        logic [18:0] vpn2;
        logic [9:0]  asid;
        logic [5:0]  ps;
        logic        g;
        logic        e;
        tlb_page_t   p0;            // even page.
        tlb_page_t   p1;            // odd page.
    } tlb_entry_t;

    // vpn2 compare, huge pages only look at the top 10 bits.
    function automatic logic vpn_match(
        input tlb_entry_t                ent,
        input logic [`TLB_VA_W-1:0]      va
    );
        if (ent.ps == PS_4M) begin
            return ent.vpn2[18:9] == va[`TLB_VA_W-1:22];
        end else begin
            return ent.vpn2 == va[`TLB_VA_W-1:13];
        end
    endfunction

endpackage

//--- hw/tlb_op_pkg.sv
`include "tlb_settings.svh"

package tlb_op_pkg;

    // INVTLB op field. code 7 is a no-op.
    typedef enum logic [2:0] {
        INV_ALL0         = 3'd0,
        INV_ALL          = 3'd1,
        INV_G1           = 3'd2,
        INV_G0           = 3'd3,
        INV_G0_ASID      = 3'd4,
        INV_G0_ASID_VA   = 3'd5,
        INV_G_OR_ASID_VA = 3'd6
    } inv_op_t;

    // one search port's answer, all zero on a miss.
    typedef struct packed {
        logic                        found;
        logic [`TLB_IDX_W-1:0]       index;
        logic [5:0]                  ps;
        tlb_entry_pkg::tlb_page_t    page;
    } tlb_result_t;

endpackage

//--- hw/tlb_memory.sv
`timescale 1ns/1ps
`include "tlb_settings.svh"

module tlb_memory (
    input  logic                         clk,
    input  logic                         rst_n,

    // write port, TLBWR / TLBFILL.
    input  logic                         we,
    input  logic [`TLB_IDX_W-1:0]        w_index,
    input  tlb_entry_pkg::tlb_entry_t    w_entry,

    // read port, TLBRD.
    input  logic [`TLB_IDX_W-1:0]        r_index,
    output tlb_entry_pkg::tlb_entry_t    r_entry,

    // INVTLB.
    input  logic                         inv_valid,
    input  tlb_op_pkg::inv_op_t          inv_op,
    input  logic [9:0]                   inv_asid,
    input  logic [`TLB_VA_W-1:0]         inv_va,

    // every entry, for the search ports.
    output tlb_entry_pkg::tlb_entry_t    all_entries [`TLB_NUM]
);

    tlb_entry_pkg::tlb_entry_t mem [`TLB_NUM];

    logic [`TLB_NUM-1:0] glob;      // g bit per entry.
    logic [`TLB_NUM-1:0] asid_eq;   // stored asid equals inv_asid.
    logic [`TLB_NUM-1:0] va_eq;     // vpn matches inv_va under entry ps.
    logic [`TLB_NUM-1:0] inv_hit;   // entries to clear this cycle.

    tlb_entry_pkg::tlb_entry_t r_sel;

    // per-entry compare terms for the invalidation engine
    for (genvar i = 0; i < `TLB_NUM; i++) begin : g_inv_cmp
        assign glob[i]    = mem[i].g;
        assign asid_eq[i] = mem[i].asid == inv_asid;
        assign va_eq[i]   = tlb_entry_pkg::vpn_match(mem[i], inv_va);
    end

    always_comb begin
        case (inv_op)
            tlb_op_pkg::INV_ALL0,
            tlb_op_pkg::INV_ALL: begin
                inv_hit = '1;
            end
            tlb_op_pkg::INV_G1: begin
                inv_hit = glob;
            end
            tlb_op_pkg::INV_G0: begin
                inv_hit = ~glob;
            end
            tlb_op_pkg::INV_G0_ASID: begin
                inv_hit = ~glob & asid_eq;
            end
            tlb_op_pkg::INV_G0_ASID_VA: begin
                inv_hit = ~glob & asid_eq & va_eq;
            end
            tlb_op_pkg::INV_G_OR_ASID_VA: begin
                inv_hit = (glob | asid_eq) & va_eq;
            end
            default: begin
                inv_hit = '0;           // op 7.
            end
        endcase
    end

    // only the exist bits see reset; payload is don't-care until written.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int j = 0; j < `TLB_NUM; j++) begin
                mem[j].e <= 1'b0;
            end
        end else if (inv_valid) begin
            // a write in the same cycle is dropped
            for (int j = 0; j < `TLB_NUM; j++) begin
                if (inv_hit[j]) begin
                    mem[j].e <= 1'b0;
                end
            end
        end else if (we) begin
            mem[w_index] <= w_entry;
        end
    end

    // read port, all fields masked by e.
    assign r_sel   = mem[r_index];
    assign r_entry = r_sel.e ? r_sel : '0;

    assign all_entries = mem;

endmodule

//--- hw/tlb_match.sv
`timescale 1ns/1ps
`include "tlb_settings.svh"

module tlb_match (
    input  tlb_entry_pkg::tlb_entry_t    all_entries [`TLB_NUM],
    input  logic [`TLB_VA_W-1:0]         va,
    input  logic [9:0]                   asid,
    output tlb_op_pkg::tlb_result_t      result
);

    localparam int IDX_W = `TLB_IDX_W;

    logic [`TLB_NUM-1:0]       hit;
    logic                      found;
    logic [IDX_W-1:0]          idx;
    tlb_entry_pkg::tlb_entry_t sel;
    logic                      odd;

    // exist, asid/global and vpn compare, one bit per entry
    for (genvar i = 0; i < `TLB_NUM; i++) begin : g_hit
        assign hit[i] = all_entries[i].e
                     && (all_entries[i].g || all_entries[i].asid == asid)
                     && tlb_entry_pkg::vpn_match(all_entries[i], va);
    end

    // lowest index wins, so scan from the top down.
    always_comb begin
        found = 1'b0;
        idx   = '0;
        for (int i = `TLB_NUM - 1; i >= 0; i--) begin
            if (hit[i]) begin
                found = 1'b1;
                idx   = IDX_W'(i);
            end
        end
    end

    assign sel = all_entries[idx];

    // odd/even select bit follows the page size.
    assign odd = (sel.ps == tlb_entry_pkg::PS_4M) ? va[21] : va[12];

    always_comb begin
        result.found = found;
        result.index = idx;         // already zero on a miss.
        if (found) begin
            result.ps   = sel.ps;
            result.page = odd ? sel.p1 : sel.p0;
        end else begin
            result.ps   = '0;
            result.page = '0;
        end
    end

endmodule

//--- hw/tlb_top.sv
`timescale 1ns/1ps
`include "tlb_settings.svh"

module tlb_top (
    input  logic                         clk,
    input  logic                         rst_n,

    // TLBWR / TLBFILL.
    input  logic                         we,
    input  logic [`TLB_IDX_W-1:0]        w_index,
    input  tlb_entry_pkg::tlb_entry_t    w_entry,

    // TLBRD.
    input  logic [`TLB_IDX_W-1:0]        r_index,
    output tlb_entry_pkg::tlb_entry_t    r_entry,

    // INVTLB.
    input  logic                         inv_valid,
    input  tlb_op_pkg::inv_op_t          inv_op,
    input  logic [9:0]                   inv_asid,
    input  logic [`TLB_VA_W-1:0]         inv_va,

    // instruction fetch search.
    input  logic [`TLB_VA_W-1:0]         fetch_va,
    input  logic [9:0]                   fetch_asid,
    output tlb_op_pkg::tlb_result_t      fetch_result,

    // load/store search, also TLBSRCH.
    input  logic [`TLB_VA_W-1:0]         data_va,
    input  logic [9:0]                   data_asid,
    output tlb_op_pkg::tlb_result_t      data_result
);

    tlb_entry_pkg::tlb_entry_t all_entries [`TLB_NUM];

    tlb_memory u_memory (
        .clk         (clk),
        .rst_n       (rst_n),
        .we          (we),
        .w_index     (w_index),
        .w_entry     (w_entry),
        .r_index     (r_index),
        .r_entry     (r_entry),
        .inv_valid   (inv_valid),
        .inv_op      (inv_op),
        .inv_asid    (inv_asid),
        .inv_va      (inv_va),
        .all_entries (all_entries)
    );

    tlb_match u_fetch_match (
        .all_entries (all_entries),
        .va          (fetch_va),
        .asid        (fetch_asid),
        .result      (fetch_result)
    );

    tlb_match u_data_match (
        .all_entries (all_entries),
        .va          (data_va),
        .asid        (data_asid),
        .result      (data_result)
    );

endmodule

//--- tb/tlb_model.svh
`ifndef TLB_MODEL_SVH
`define TLB_MODEL_SVH

`include "tlb_settings.svh"

localparam int IDX_W = `TLB_IDX_W;

tlb_entry_pkg::tlb_entry_t model_mem [`TLB_NUM];   // mirror of the TLB array.

int check_count = 0;
int error_count = 0;

// a 4MB page only compares va[31:22].
function automatic logic model_va_hit(
    input tlb_entry_pkg::tlb_entry_t ent,
    input logic [`TLB_VA_W-1:0]      va
);
    if (ent.ps == 6'd21) begin
        return ent.vpn2[18:9] == va[`TLB_VA_W-1:22];
    end
    return ent.vpn2 == va[`TLB_VA_W-1:13];
endfunction

function automatic void model_write(
    input logic [IDX_W-1:0]          idx,
    input tlb_entry_pkg::tlb_entry_t ent
);
    model_mem[idx] = ent;
endfunction

function automatic tlb_entry_pkg::tlb_entry_t model_read(input logic [IDX_W-1:0] idx);
    if (model_mem[idx].e) begin
        return model_mem[idx];
    end
    return '0;
endfunction

function automatic void model_invalidate(
    input tlb_op_pkg::inv_op_t  op,
    input logic [9:0]           asid,
    input logic [`TLB_VA_W-1:0] va
);
    tlb_entry_pkg::tlb_entry_t ent;
    logic                      clear;
    for (int i = 0; i < `TLB_NUM; i++) begin
        ent = model_mem[i];
        case (op)
            tlb_op_pkg::INV_ALL0, tlb_op_pkg::INV_ALL: clear = 1'b1;
            tlb_op_pkg::INV_G1:           clear = ent.g;
            tlb_op_pkg::INV_G0:           clear = !ent.g;
            tlb_op_pkg::INV_G0_ASID:      clear = !ent.g && ent.asid == asid;
            tlb_op_pkg::INV_G0_ASID_VA:   clear = !ent.g && ent.asid == asid
                                                  && model_va_hit(ent, va);
            tlb_op_pkg::INV_G_OR_ASID_VA: clear = (ent.g || ent.asid == asid)
                                                  && model_va_hit(ent, va);
            default:                      clear = 1'b0;
        endcase
        if (clear) begin
            model_mem[i].e = 1'b0;
        end
    end
endfunction

// first matching entry from index 0 up.
function automatic tlb_op_pkg::tlb_result_t model_search(
    input logic [`TLB_VA_W-1:0] va,
    input logic [9:0]           asid
);
    tlb_op_pkg::tlb_result_t   res;
    tlb_entry_pkg::tlb_entry_t ent;
    logic                      odd;
    res = '0;
    for (int i = 0; i < `TLB_NUM; i++) begin
        ent = model_mem[i];
        if (!res.found && ent.e && (ent.g || ent.asid == asid) && model_va_hit(ent, va)) begin
            odd       = (ent.ps == 6'd21) ? va[21] : va[12];
            res.found = 1'b1;
            res.index = IDX_W'(i);
            res.ps    = ent.ps;
            res.page  = odd ? ent.p1 : ent.p0;
        end
    end
    return res;
endfunction

task automatic check_entry(
    input string                     what,
    input tlb_entry_pkg::tlb_entry_t got,
    input tlb_entry_pkg::tlb_entry_t exp
);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("[FAIL] %0.1f ns %s: entry %h, expected %h", $realtime, what, got, exp);
    end
endtask

task automatic check_result(
    input string                   what,
    input tlb_op_pkg::tlb_result_t got,
    input tlb_op_pkg::tlb_result_t exp
);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("[FAIL] %0.1f ns %s: result %h, expected %h", $realtime, what, got, exp);
    end
endtask

`endif

//--- tb/tb_tlb.sv
`timescale 1ns/1ps
`include "tlb_settings.svh"

module tb_tlb;

    `include "tlb_model.svh"

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int N_SEARCH     = 200;
    localparam int N_INV_REPS   = 4;
    localparam int N_WIN_REPS   = 4;
    localparam int TEST_CYCLES  = 2 * `TLB_NUM + N_SEARCH + 2 * `TLB_NUM
                                + 4 * (2 * `TLB_NUM + 1)
                                + 3 * N_INV_REPS * (2 * `TLB_NUM + 2)
                                + N_WIN_REPS * (2 * `TLB_NUM + 1);
    localparam int WATCHDOG_NS  = (RESET_CYCLES + TEST_CYCLES + 64) * CLK_PERIOD;

    logic                      clk;
    logic                      rst_n;
    logic                      we;
    logic [IDX_W-1:0]          w_index;
    tlb_entry_pkg::tlb_entry_t w_entry;
    logic [IDX_W-1:0]          r_index;
    tlb_entry_pkg::tlb_entry_t r_entry;
    logic                      inv_valid;
    tlb_op_pkg::inv_op_t       inv_op;
    logic [9:0]                inv_asid;
    logic [`TLB_VA_W-1:0]      inv_va;
    logic [`TLB_VA_W-1:0]      fetch_va;
    logic [9:0]                fetch_asid;
    tlb_op_pkg::tlb_result_t   fetch_result;
    logic [`TLB_VA_W-1:0]      data_va;
    logic [9:0]                data_asid;
    tlb_op_pkg::tlb_result_t   data_result;
    logic [31:0]               lcg_state;

    tlb_top uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .we           (we),
        .w_index      (w_index),
        .w_entry      (w_entry),
        .r_index      (r_index),
        .r_entry      (r_entry),
        .inv_valid    (inv_valid),
        .inv_op       (inv_op),
        .inv_asid     (inv_asid),
        .inv_va       (inv_va),
        .fetch_va     (fetch_va),
        .fetch_asid   (fetch_asid),
        .fetch_result (fetch_result),
        .data_va      (data_va),
        .data_asid    (data_asid),
        .data_result  (data_result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [15:0] next_rand16();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];   // the low bits of an LCG cycle fast.
    endfunction

    function automatic logic [31:0] rand_word();
        logic [15:0] hi;
        hi = next_rand16();
        return {hi, next_rand16()};
    endfunction

    // small pool so entries collide and 4MB pages share vpn2[18:9].
    function automatic logic [18:0] pool_vpn(input logic [1:0] sel);
        case (sel)
            2'd0:    return 19'h12345;
            2'd1:    return 19'h12344;
            2'd2:    return 19'h12200;
            default: return 19'h7abcd;
        endcase
    endfunction

    function automatic logic [9:0] pool_asid(input logic [1:0] sel);
        return {8'h00, sel} + 10'h011;
    endfunction

    function automatic tlb_entry_pkg::tlb_entry_t random_entry();
        tlb_entry_pkg::tlb_entry_t ent;
        logic [15:0]               r;
        logic [31:0]               w0;
        logic [31:0]               w1;
        r       = next_rand16();
        w0      = rand_word();
        w1      = rand_word();
        ent.ps   = r[0] ? 6'd21 : 6'd12;
        ent.g    = (r[2:1] == 2'b00);
        ent.e    = (r[4:3] != 2'b00);
        ent.asid = pool_asid(r[6:5]);
        ent.vpn2 = pool_vpn(r[8:7]);
        ent.p0   = w0[25:0];
        ent.p1   = w1[25:0];
        return ent;
    endfunction

    function automatic logic [`TLB_VA_W-1:0] random_va();
        logic [15:0] r;
        logic [31:0] w;
        r = next_rand16();
        w = rand_word();
        if (r[2:0] == 3'd0) begin
            return w;           // mostly a miss.
        end
        return {pool_vpn(r[4:3]), w[12:0]};
    endfunction

    function automatic logic [9:0] random_asid();
        logic [15:0] r;
        r = next_rand16();
        if (r[1:0] == 2'd0) begin
            return r[11:2];
        end
        return pool_asid(r[3:2]);
    endfunction

    task automatic write_cycle(
        input logic [IDX_W-1:0]          idx,
        input tlb_entry_pkg::tlb_entry_t ent
    );
        @(negedge clk);
        inv_valid = 1'b0;
        we        = 1'b1;
        w_index   = idx;
        w_entry   = ent;
        model_write(idx, ent);
    endtask

    task automatic invalidate_cycle(
        input tlb_op_pkg::inv_op_t       op,
        input logic [9:0]                asid,
        input logic [`TLB_VA_W-1:0]      va,
        input logic                      with_write,
        input logic [IDX_W-1:0]          idx,
        input tlb_entry_pkg::tlb_entry_t ent
    );
        @(negedge clk);
        inv_valid = 1'b1;
        inv_op    = op;
        inv_asid  = asid;
        inv_va    = va;
        we        = with_write;
        w_index   = idx;
        w_entry   = ent;
        model_invalidate(op, asid, va);    // the write is dropped.
    endtask

    task automatic read_cycle(input int idx, input string tag);
        @(negedge clk);
        we        = 1'b0;
        inv_valid = 1'b0;
        r_index   = IDX_W'(idx);
        #1.5;
        check_entry($sformatf("%s read %0d", tag, idx), r_entry, model_read(IDX_W'(idx)));
    endtask

    task automatic search_cycle(
        input logic [`TLB_VA_W-1:0] fva,
        input logic [9:0]           fasid,
        input logic [`TLB_VA_W-1:0] dva,
        input logic [9:0]           dasid,
        input string                tag
    );
        @(negedge clk);
        we         = 1'b0;
        inv_valid  = 1'b0;
        fetch_va   = fva;
        fetch_asid = fasid;
        data_va    = dva;
        data_asid  = dasid;
        #1.5;
        check_result($sformatf("%s fetch va %h", tag, fva), fetch_result,
                     model_search(fva, fasid));
        check_result($sformatf("%s data va %h", tag, dva), data_result,
                     model_search(dva, dasid));
    endtask

    task automatic refill_table();
        for (int i = 0; i < `TLB_NUM; i++) begin
            write_cycle(IDX_W'(i), random_entry());
        end
    endtask

    task automatic read_all(input string tag);
        for (int i = 0; i < `TLB_NUM; i++) begin
            read_cycle(i, tag);
        end
    endtask

    task automatic report_test(input string name, input int errors_at_start);
        if (error_count == errors_at_start) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: failed, %0d errors", name, error_count - errors_at_start);
        end
    endtask

    initial begin
        #WATCHDOG_NS;
        $display("timeout: the test sequence did not finish within %0d ns", WATCHDOG_NS);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        int                        start;
        tlb_entry_pkg::tlb_entry_t ent;
        logic [15:0]               r;
        logic [31:0]               w;
        logic [9:0]                asid;
        logic [`TLB_VA_W-1:0]      va;
        lcg_state  = 32'd18;
        rst_n      = 1'b0;
        we         = 1'b0;
        w_index    = '0;
        w_entry    = '0;
        r_index    = '0;
        inv_valid  = 1'b1;                 // op 1 during reset.
        inv_op     = tlb_op_pkg::INV_ALL;
        inv_asid   = '0;
        inv_va     = '0;
        fetch_va   = '0;
        fetch_asid = '0;
        data_va    = '0;
        data_asid  = '0;
        for (int i = 0; i < `TLB_NUM; i++) begin
            model_mem[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n     = 1'b1;
        inv_valid = 1'b0;

        start = error_count;
        refill_table();
        read_all("wr");
        report_test("write then read back", start);

        start = error_count;
        for (int n = 0; n < N_SEARCH; n++) begin
            search_cycle(random_va(), random_asid(), random_va(), random_asid(), "search");
        end
        report_test("fetch and data search", start);

        start = error_count;
        refill_table();
        for (int i = 0; i < `TLB_NUM; i++) begin
            ent = model_mem[i];
            w   = rand_word();
            va  = {ent.vpn2, w[12:0]};
            // own asid on fetch and a foreign one on data.
            search_cycle(va, ent.asid, va, ent.asid ^ 10'h200, "mask");
        end
        report_test("global and asid masking", start);

        start = error_count;
        for (int op = 0; op < 4; op++) begin
            refill_table();
            invalidate_cycle(tlb_op_pkg::inv_op_t'(3'(op)), random_asid(), random_va(),
                             1'b0, '0, '0);
            read_all($sformatf("inv op %0d", op));
        end
        report_test("invalidate ops 0 to 3", start);

        start = error_count;
        for (int op = 4; op < 7; op++) begin
            for (int rep = 0; rep < N_INV_REPS; rep++) begin
                refill_table();
                r    = next_rand16();
                w    = rand_word();
                ent  = model_mem[r[15:8] % `TLB_NUM];
                asid = r[4] ? ent.asid : random_asid();
                va   = {ent.vpn2, w[12:0]};    // aim at a stored entry.
                invalidate_cycle(tlb_op_pkg::inv_op_t'(3'(op)), asid, va, 1'b0, '0, '0);
                read_all($sformatf("inv op %0d", op));
                search_cycle(va, asid, va, random_asid(), $sformatf("inv op %0d", op));
            end
        end
        report_test("invalidate ops 4 to 6", start);

        start = error_count;
        for (int rep = 0; rep < N_WIN_REPS; rep++) begin
            refill_table();
            r     = next_rand16();
            ent   = random_entry();
            ent.e = 1'b1;
            invalidate_cycle(tlb_op_pkg::inv_op_t'({1'b1, r[1:0]}), random_asid(), random_va(),
                             1'b1, IDX_W'(r[11:4] % `TLB_NUM), ent);
            read_all("inv vs write");
        end
        report_test("invalidate wins over write", start);

        $display("summary: 6 tests, %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+include
+incdir+tb
hw/tlb_entry_pkg.sv
hw/tlb_op_pkg.sv
hw/tlb_memory.sv
hw/tlb_match.sv
hw/tlb_top.sv
tb/tb_tlb.sv

//--- run.sh
#!/bin/sh
# build and run the TLB testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f all.f --top-module tb_tlb -Mdir obj_dir -o sim_tlb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tlb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
    exit 1
fi
exit 0
